//--- design/flow_ctrl_pkg.sv
`default_nettype none

package flow_ctrl_pkg;

    // Default build configuration
    localparam int NUM_PROTOCOLS    = 4;
    localparam int VCS_PER_PROTOCOL = 4;
    localparam int FLIT_WIDTH       = 32;
    localparam int QUEUE_DEPTH      = 8;

    localparam int CREDIT_WIDTH = 8;
    localparam int PRIO_WIDTH   = 4;

    // Global VC numbering on the link side
    localparam int VC_ID_WIDTH = 8;
    localparam int MAX_VCS     = 2 ** VC_ID_WIDTH;

    typedef enum logic [2:0] {
        PCIE       = 3'd0,
        CXL_IO     = 3'd1,
        CXL_CACHE  = 3'd2,
        CXL_MEM    = 3'd3,
        STREAMING  = 3'd4,
        MANAGEMENT = 3'd5
    } protocol_t;

    typedef struct packed {
        logic [FLIT_WIDTH-1:0]  data;
        logic                   sop;
        logic                   eop;
        protocol_t              protocol;
        logic [VC_ID_WIDTH-1:0] vc_global;
        logic [PRIO_WIDTH-1:0]  prio;
    } flit_entry_t;

    // Index width that stays legal for a count of one
    function automatic int idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Remote buffer sizing per lane, lane 0 has the deepest buffers
    function automatic logic [CREDIT_WIDTH-1:0] initial_credits(input int vc,
                                                                input int vcs_per_protocol);
        if (vc < vcs_per_protocol) begin
            return CREDIT_WIDTH'(8);
        end
        if (vc < 3 * vcs_per_protocol) begin
            return CREDIT_WIDTH'(6);
        end
        return CREDIT_WIDTH'(4);
    endfunction

endpackage

`default_nettype wire

//--- design/queue_head_if.sv
`timescale 1ns/1ps
`default_nettype none

interface queue_head_if #(
    parameter int NUM_PROTOCOLS = flow_ctrl_pkg::NUM_PROTOCOLS,
    localparam int LANE_W = flow_ctrl_pkg::idx_width(NUM_PROTOCOLS)
);
    import flow_ctrl_pkg::*;

    // Head of every lane FIFO, visible to the arbiter
    logic [NUM_PROTOCOLS-1:0] head_valid;
    flit_entry_t              head_flit [NUM_PROTOCOLS];

    // One-cycle pop strobe, head leaves on the same edge
    logic                     pop;
    logic [LANE_W-1:0]        pop_lane;

    modport queue (
        output head_valid,
        output head_flit,
        input  pop,
        input  pop_lane
    );

    modport arbiter (
        input  head_valid,
        input  head_flit,
        output pop,
        output pop_lane
    );

endinterface

`default_nettype wire

//--- design/protocol_queues.sv
`timescale 1ns/1ps
`default_nettype none

module protocol_queues #(
    parameter int NUM_PROTOCOLS    = flow_ctrl_pkg::NUM_PROTOCOLS,
    parameter int VCS_PER_PROTOCOL = flow_ctrl_pkg::VCS_PER_PROTOCOL,
    parameter int QUEUE_DEPTH      = flow_ctrl_pkg::QUEUE_DEPTH,
    localparam int LVC_W = flow_ctrl_pkg::idx_width(VCS_PER_PROTOCOL)
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    flow_control_enable,
    input  logic [NUM_PROTOCOLS-1:0]                                protocol_enable,
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_valid,
    input  logic [NUM_PROTOCOLS-1:0][flow_ctrl_pkg::FLIT_WIDTH-1:0] ul_flit_data,
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_sop,
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_eop,
    input  flow_ctrl_pkg::protocol_t [NUM_PROTOCOLS-1:0]            ul_protocol_type,
    input  logic [NUM_PROTOCOLS-1:0][LVC_W-1:0]                     ul_vc_id,
    input  logic [NUM_PROTOCOLS-1:0][flow_ctrl_pkg::PRIO_WIDTH-1:0] ul_priority,
    output logic [NUM_PROTOCOLS-1:0]                                ul_flit_ready,
    queue_head_if.queue                                             heads
);
    import flow_ctrl_pkg::*;

    localparam int LANE_W = idx_width(NUM_PROTOCOLS);
    localparam int PTR_W  = idx_width(QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);

    for (genvar l = 0; l < NUM_PROTOCOLS; l++) begin : g_lane
        flit_entry_t      mem [QUEUE_DEPTH];
        flit_entry_t      wr_entry;
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             lane_en;
        logic             push;
        logic             pop_here;

        assign lane_en          = flow_control_enable && protocol_enable[l];
        assign ul_flit_ready[l] = lane_en && (count < CNT_W'(QUEUE_DEPTH));
        assign push             = ul_flit_valid[l] && ul_flit_ready[l];
        assign pop_here         = heads.pop && (heads.pop_lane == LANE_W'(l));

        // Lane-local VC folded into the global VC space
        assign wr_entry = '{
            data:      ul_flit_data[l],
            sop:       ul_flit_sop[l],
            eop:       ul_flit_eop[l],
            protocol:  ul_protocol_type[l],
            vc_global: VC_ID_WIDTH'(l * VCS_PER_PROTOCOL) + VC_ID_WIDTH'(ul_vc_id[l]),
            prio:      ul_priority[l]
        };

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= wr_entry;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop_here) begin
                    rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, pop_here})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        // Disabled lanes keep their contents but stop presenting
        assign heads.head_valid[l] = lane_en && (count != '0);
        assign heads.head_flit[l]  = mem[rd_ptr];

        a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
            count <= CNT_W'(QUEUE_DEPTH));
        a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
            pop_here |-> (count != '0));
    end

endmodule

`default_nettype wire

//--- design/credit_ledger.sv
`timescale 1ns/1ps
`default_nettype none

module credit_ledger #(
    parameter int NUM_PROTOCOLS    = flow_ctrl_pkg::NUM_PROTOCOLS,
    parameter int VCS_PER_PROTOCOL = flow_ctrl_pkg::VCS_PER_PROTOCOL,
    localparam int TOTAL_VCS = NUM_PROTOCOLS * VCS_PER_PROTOCOL
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                consume,
    input  logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0]               consume_vc,
    input  logic                                                credit_return_valid,
    input  logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0]               credit_return_vc,
    input  logic [flow_ctrl_pkg::CREDIT_WIDTH-1:0]              credit_return_count,
    output logic [flow_ctrl_pkg::MAX_VCS-1:0]                   vc_has_credit,
    output logic [TOTAL_VCS-1:0][flow_ctrl_pkg::CREDIT_WIDTH-1:0] credit_available
);
    import flow_ctrl_pkg::*;

    for (genvar v = 0; v < TOTAL_VCS; v++) begin : g_vc
        logic [CREDIT_WIDTH-1:0] credit_q;
        logic [CREDIT_WIDTH:0]   next_sum;
        logic                    take;
        logic                    give;

        assign take = consume && (consume_vc == VC_ID_WIDTH'(v));
        assign give = credit_return_valid && (credit_return_vc == VC_ID_WIDTH'(v));

        // Consume and return on the same edge both apply
        assign next_sum = {1'b0, credit_q}
                        + (give ? {1'b0, credit_return_count} : '0)
                        - {{CREDIT_WIDTH{1'b0}}, take};

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                credit_q <= initial_credits(v, VCS_PER_PROTOCOL);
            end else if (take || give) begin
                // Saturate at the counter maximum
                credit_q <= next_sum[CREDIT_WIDTH] ? '1 : next_sum[CREDIT_WIDTH-1:0];
            end
        end

        assign credit_available[v] = credit_q;
        assign vc_has_credit[v]    = (credit_q != '0);

        a_no_consume_empty: assert property (@(posedge clk) disable iff (!rst_n)
            take |-> (credit_q != '0));
    end

    // VC numbers beyond the configured range never have credit
    if (TOTAL_VCS < MAX_VCS) begin : g_pad
        assign vc_has_credit[MAX_VCS-1:TOTAL_VCS] = '0;
    end

endmodule

`default_nettype wire

//--- design/priority_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module priority_arbiter #(
    parameter int NUM_PROTOCOLS = flow_ctrl_pkg::NUM_PROTOCOLS
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flow_control_enable,
    input  logic [flow_ctrl_pkg::MAX_VCS-1:0]     vc_has_credit,
    input  logic                                  stage_free,
    output logic                                  consume,
    output logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0] consume_vc,
    output logic                                  grant_valid,
    output flow_ctrl_pkg::flit_entry_t            grant_flit,
    queue_head_if.arbiter                         heads
);
    import flow_ctrl_pkg::*;

    localparam int LANE_W = idx_width(NUM_PROTOCOLS);

    logic [NUM_PROTOCOLS-1:0] eligible;
    logic [LANE_W-1:0]        last_winner;
    logic [LANE_W-1:0]        win_lane;
    logic [PRIO_WIDTH-1:0]    best_prio;
    logic                     found;
    logic                     grant;
    logic                     higher_waiting;

    // A head may only compete once its VC holds credit
    always_comb begin
        for (int l = 0; l < NUM_PROTOCOLS; l++) begin
            eligible[l] = heads.head_valid[l] && vc_has_credit[heads.head_flit[l].vc_global];
        end
    end

    // Round-robin scan from the lane after the last winner
    // Strict compare keeps the earliest lane on a tie
    always_comb begin
        int idx;
        found     = 1'b0;
        best_prio = '0;
        win_lane  = last_winner;
        for (int i = 1; i <= NUM_PROTOCOLS; i++) begin
            idx = (int'(last_winner) + i) % NUM_PROTOCOLS;
            if (eligible[idx] && (!found || (heads.head_flit[idx].prio > best_prio))) begin
                found     = 1'b1;
                best_prio = heads.head_flit[idx].prio;
                win_lane  = LANE_W'(idx);
            end
        end
    end

    assign grant = found && stage_free && flow_control_enable;

    // Pop, consume and output load share one edge
    assign heads.pop      = grant;
    assign heads.pop_lane = win_lane;
    assign consume        = grant;
    assign consume_vc     = heads.head_flit[win_lane].vc_global;
    assign grant_valid    = grant;
    assign grant_flit     = heads.head_flit[win_lane];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_winner <= '0;
        end else if (grant) begin
            last_winner <= win_lane;
        end
    end

    // No eligible head outranks the granted flit
    always_comb begin
        higher_waiting = 1'b0;
        for (int l = 0; l < NUM_PROTOCOLS; l++) begin
            if (eligible[l] && (heads.head_flit[l].prio > grant_flit.prio)) begin
                higher_waiting = 1'b1;
            end
        end
    end

    a_pop_head_valid: assert property (@(posedge clk) disable iff (!rst_n)
        heads.pop |-> (heads.head_valid[heads.pop_lane] && !higher_waiting));

endmodule

`default_nettype wire

//--- design/flit_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module flit_out_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  grant_valid,
    input  flow_ctrl_pkg::flit_entry_t            grant_flit,
    input  logic                                  dl_flit_ready,
    output logic                                  stage_free,
    output logic                                  dl_flit_valid,
    output logic [flow_ctrl_pkg::FLIT_WIDTH-1:0]  dl_flit_data,
    output logic                                  dl_flit_sop,
    output logic                                  dl_flit_eop,
    output flow_ctrl_pkg::protocol_t              dl_protocol_type,
    output logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0] dl_vc_global_id
);
    import flow_ctrl_pkg::*;

    flit_entry_t out_q;

    // Empty, or draining on this edge
    assign stage_free = !dl_flit_valid || dl_flit_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dl_flit_valid <= 1'b0;
        end else if (grant_valid) begin
            dl_flit_valid <= 1'b1;
        end else if (dl_flit_ready) begin
            dl_flit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            out_q <= grant_flit;
        end
    end

    assign dl_flit_data     = out_q.data;
    assign dl_flit_sop      = out_q.sop;
    assign dl_flit_eop      = out_q.eop;
    assign dl_protocol_type = out_q.protocol;
    assign dl_vc_global_id  = out_q.vc_global;

    a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (dl_flit_valid && !dl_flit_ready) |=> (dl_flit_valid && $stable(out_q)));

endmodule

`default_nettype wire

//--- design/flow_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module flow_ctrl_top #(
    parameter int NUM_PROTOCOLS    = flow_ctrl_pkg::NUM_PROTOCOLS,
    parameter int VCS_PER_PROTOCOL = flow_ctrl_pkg::VCS_PER_PROTOCOL,
    parameter int QUEUE_DEPTH      = flow_ctrl_pkg::QUEUE_DEPTH,
    localparam int TOTAL_VCS = NUM_PROTOCOLS * VCS_PER_PROTOCOL,
    localparam int LVC_W     = flow_ctrl_pkg::idx_width(VCS_PER_PROTOCOL)
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    flow_control_enable,
    input  logic [NUM_PROTOCOLS-1:0]                                protocol_enable,
    // Upstream protocol lanes
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_valid,
    input  logic [NUM_PROTOCOLS-1:0][flow_ctrl_pkg::FLIT_WIDTH-1:0] ul_flit_data,
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_sop,
    input  logic [NUM_PROTOCOLS-1:0]                                ul_flit_eop,
    input  flow_ctrl_pkg::protocol_t [NUM_PROTOCOLS-1:0]            ul_protocol_type,
    input  logic [NUM_PROTOCOLS-1:0][LVC_W-1:0]                     ul_vc_id,
    input  logic [NUM_PROTOCOLS-1:0][flow_ctrl_pkg::PRIO_WIDTH-1:0] ul_priority,
    output logic [NUM_PROTOCOLS-1:0]                                ul_flit_ready,
    // Downstream flit stream
    output logic                                                    dl_flit_valid,
    output logic [flow_ctrl_pkg::FLIT_WIDTH-1:0]                    dl_flit_data,
    output logic                                                    dl_flit_sop,
    output logic                                                    dl_flit_eop,
    output flow_ctrl_pkg::protocol_t                                dl_protocol_type,
    output logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0]                   dl_vc_global_id,
    input  logic                                                    dl_flit_ready,
    // Credits from the remote side
    input  logic                                                    credit_return_valid,
    input  logic [flow_ctrl_pkg::VC_ID_WIDTH-1:0]                   credit_return_vc,
    input  logic [flow_ctrl_pkg::CREDIT_WIDTH-1:0]                  credit_return_count,
    output logic [TOTAL_VCS-1:0][flow_ctrl_pkg::CREDIT_WIDTH-1:0]   credit_available
);
    import flow_ctrl_pkg::*;

    logic                   consume;
    logic [VC_ID_WIDTH-1:0] consume_vc;
    logic [MAX_VCS-1:0]     vc_has_credit;
    logic                   grant_valid;
    flit_entry_t            grant_flit;
    logic                   stage_free;

    queue_head_if #(.NUM_PROTOCOLS(NUM_PROTOCOLS)) heads ();

    protocol_queues #(
        .NUM_PROTOCOLS   (NUM_PROTOCOLS),
        .VCS_PER_PROTOCOL(VCS_PER_PROTOCOL),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) u_queues (
        .clk                (clk),
        .rst_n              (rst_n),
        .flow_control_enable(flow_control_enable),
        .protocol_enable    (protocol_enable),
        .ul_flit_valid      (ul_flit_valid),
        .ul_flit_data       (ul_flit_data),
        .ul_flit_sop        (ul_flit_sop),
        .ul_flit_eop        (ul_flit_eop),
        .ul_protocol_type   (ul_protocol_type),
        .ul_vc_id           (ul_vc_id),
        .ul_priority        (ul_priority),
        .ul_flit_ready      (ul_flit_ready),
        .heads              (heads)
    );

    credit_ledger #(
        .NUM_PROTOCOLS   (NUM_PROTOCOLS),
        .VCS_PER_PROTOCOL(VCS_PER_PROTOCOL)
    ) u_ledger (
        .clk                (clk),
        .rst_n              (rst_n),
        .consume            (consume),
        .consume_vc         (consume_vc),
        .credit_return_valid(credit_return_valid),
        .credit_return_vc   (credit_return_vc),
        .credit_return_count(credit_return_count),
        .vc_has_credit      (vc_has_credit),
        .credit_available   (credit_available)
    );

    priority_arbiter #(
        .NUM_PROTOCOLS(NUM_PROTOCOLS)
    ) u_arbiter (
        .clk                (clk),
        .rst_n              (rst_n),
        .flow_control_enable(flow_control_enable),
        .vc_has_credit      (vc_has_credit),
        .stage_free         (stage_free),
        .consume            (consume),
        .consume_vc         (consume_vc),
        .grant_valid        (grant_valid),
        .grant_flit         (grant_flit),
        .heads              (heads)
    );

    flit_out_stage u_out (
        .clk             (clk),
        .rst_n           (rst_n),
        .grant_valid     (grant_valid),
        .grant_flit      (grant_flit),
        .dl_flit_ready   (dl_flit_ready),
        .stage_free      (stage_free),
        .dl_flit_valid   (dl_flit_valid),
        .dl_flit_data    (dl_flit_data),
        .dl_flit_sop     (dl_flit_sop),
        .dl_flit_eop     (dl_flit_eop),
        .dl_protocol_type(dl_protocol_type),
        .dl_vc_global_id (dl_vc_global_id)
    );

endmodule

`default_nettype wire

//--- testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic stop_on_error();
    errors++;
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_eq(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
    assert (actual === expected) else begin
        $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
        stop_on_error();
    end
endtask

task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
        $display("%s", what);
        stop_on_error();
    end
endtask

function automatic void note_consume(input int vc);
    exp_credit[vc] = exp_credit[vc] - 1'b1;
endfunction

// Returns saturate at the counter maximum
function automatic void note_return(input int vc, input int count);
    int sum;
    sum = int'(exp_credit[vc]) + count;
    exp_credit[vc] = (sum > (1 << CREDIT_WIDTH) - 1) ? '1 : CREDIT_WIDTH'(sum);
endfunction

task automatic check_credits();
    for (int v = 0; v < TOTAL_VCS; v++) begin
        check_eq($sformatf("credit_available[%0d]", v), 64'(exp_credit[v]),
                 64'(credit_available[v]));
    end
endtask

function automatic flit_entry_t build_flit(input int lane, input int lvc, input int prio,
                                           input protocol_t proto);
    flit_entry_t f;
    f.data      = $urandom();
    f.sop       = 1'($urandom());
    f.eop       = 1'($urandom());
    f.protocol  = proto;
    // Lane-local VC mapped into the global numbering
    f.vc_global = VC_ID_WIDTH'(lane * VPP + lvc);
    f.prio      = PRIO_WIDTH'(prio);
    return f;
endfunction

task automatic drive_lane(input int lane, input flit_entry_t f);
    ul_flit_valid[lane]    = 1'b1;
    ul_flit_data[lane]     = f.data;
    ul_flit_sop[lane]      = f.sop;
    ul_flit_eop[lane]      = f.eop;
    ul_protocol_type[lane] = f.protocol;
    ul_vc_id[lane]         = LVC_W'(int'(f.vc_global) % VPP);
    ul_priority[lane]      = f.prio;
endtask

task automatic send_flit(input int lane, input flit_entry_t f);
    drive_lane(lane, f);
    while (!ul_flit_ready[lane]) begin
        @(negedge clk);
    end
    @(negedge clk);
    ul_flit_valid[lane] = 1'b0;
endtask

task automatic return_credit(input int vc, input int count);
    credit_return_valid = 1'b1;
    credit_return_vc    = VC_ID_WIDTH'(vc);
    credit_return_count = CREDIT_WIDTH'(count);
    @(negedge clk);
    credit_return_valid = 1'b0;
    note_return(vc, count);
endtask

task automatic expect_flit(input flit_entry_t exp);
    flit_entry_t got;
    while (got_q.size() == 0) begin
        @(negedge clk);
    end
    got = got_q.pop_front();
    check_eq("dl_flit_data", 64'(exp.data), 64'(got.data));
    check_eq("dl_flit_sop", 64'(exp.sop), 64'(got.sop));
    check_eq("dl_flit_eop", 64'(exp.eop), 64'(got.eop));
    check_eq("dl_protocol_type", 64'(exp.protocol), 64'(got.protocol));
    check_eq("dl_vc_global_id", 64'(exp.vc_global), 64'(got.vc_global));
endtask

task automatic test_reset_state();
    check_eq("dl_flit_valid", 64'(0), 64'(dl_flit_valid));
    check_credits();
    check_eq("ul_flit_ready", 64'({NP{1'b1}}), 64'(ul_flit_ready));
    protocol_enable[1] = 1'b0;
    @(negedge clk);
    check_eq("ul_flit_ready", 64'(protocol_enable), 64'(ul_flit_ready));
    flow_control_enable = 1'b0;
    @(negedge clk);
    check_eq("ul_flit_ready", 64'(0), 64'(ul_flit_ready));
    flow_control_enable = 1'b1;
    protocol_enable     = '1;
    @(negedge clk);
    check_eq("ul_flit_ready", 64'({NP{1'b1}}), 64'(ul_flit_ready));
endtask

task automatic test_single_flit();
    flit_entry_t f;
    dl_flit_ready = 1'b1;
    f = build_flit(2, 3, 5, CXL_CACHE);
    send_flit(2, f);
    // One cycle after acceptance
    @(negedge clk);
    check_eq("dl_flit_valid", 64'(1), 64'(dl_flit_valid));
    expect_flit(f);
    note_consume(2 * VPP + 3);
    check_credits();
endtask

task automatic test_priority_rr();
    flit_entry_t f [NP];
    int          prio [NP]  = '{3, 9, 9, 1};
    int          order [NP] = '{1, 2, 0, 3};
    protocol_t   proto [NP] = '{PCIE, CXL_IO, CXL_CACHE, CXL_MEM};
    dl_flit_ready = 1'b0;
    for (int l = 0; l < NP; l++) begin
        f[l] = build_flit(l, 1, prio[l], proto[l]);
        drive_lane(l, f[l]);
    end
    check_eq("ul_flit_ready", 64'({NP{1'b1}}), 64'(ul_flit_ready));
    @(negedge clk);
    ul_flit_valid = '0;
    repeat (3) @(negedge clk);
    // Lanes 1 and 2 tie at the top, round-robin picks lane 1 first
    check_eq("dl_flit_valid", 64'(1), 64'(dl_flit_valid));
    check_eq("dl_flit_data", 64'(f[1].data), 64'(dl_flit_data));
    dl_flit_ready = 1'b1;
    for (int i = 0; i < NP; i++) begin
        expect_flit(f[order[i]]);
        note_consume(int'(f[order[i]].vc_global));
    end
    check_credits();
endtask

task automatic test_credit_exhaust();
    flit_entry_t f [$];
    int          vc;
    int          n;
    vc = 3 * VPP;
    n  = int'(initial_credits(vc, VPP)) + 1;
    dl_flit_ready = 1'b1;
    for (int i = 0; i < n; i++) begin
        f.push_back(build_flit(3, 0, 2, CXL_MEM));
        send_flit(3, f[i]);
    end
    for (int i = 0; i < n - 1; i++) begin
        expect_flit(f[i]);
        note_consume(vc);
    end
    repeat (4) @(negedge clk);
    check_true(got_q.size() == 0 && !dl_flit_valid,
               "a flit on lane 3 VC 0 was sent without credit");
    check_credits();
    return_credit(vc, 2);
    expect_flit(f[n-1]);
    note_consume(vc);
    check_credits();
endtask

task automatic test_backpressure_full();
    flit_entry_t f [$];
    flit_entry_t nf;
    // Enough credit for the held flit plus a full queue
    return_credit(0, QD + 1);
    dl_flit_ready = 1'b0;
    for (int i = 0; i < QD + 1; i++) begin
        nf = build_flit(0, 0, 7, STREAMING);
        f.push_back(nf);
        send_flit(0, nf);
    end
    check_eq("ul_flit_ready[0]", 64'(0), 64'(ul_flit_ready[0]));
    note_consume(0);
    repeat (3) begin
        @(negedge clk);
        check_eq("dl_flit_valid", 64'(1), 64'(dl_flit_valid));
        check_eq("dl_flit_data", 64'(f[0].data), 64'(dl_flit_data));
        check_eq("dl_vc_global_id", 64'(f[0].vc_global), 64'(dl_vc_global_id));
    end
    check_true(got_q.size() == 0, "a flit was transferred while dl_flit_ready was low");
    check_eq("ul_flit_ready[0]", 64'(0), 64'(ul_flit_ready[0]));
    check_credits();
    dl_flit_ready = 1'b1;
    for (int i = 0; i < QD + 1; i++) begin
        expect_flit(f[i]);
        if (i > 0) begin
            note_consume(0);
        end
    end
    check_credits();
endtask

`endif

//--- testbench/tb_flow_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flow_ctrl;
    import flow_ctrl_pkg::*;

    localparam int NP        = NUM_PROTOCOLS;
    localparam int VPP       = VCS_PER_PROTOCOL;
    localparam int QD        = QUEUE_DEPTH;
    localparam int TOTAL_VCS = NP * VPP;
    localparam int LVC_W     = idx_width(VPP);
    // Wide margin over the directed sequence
    localparam int TIMEOUT_CYCLES = 2000;

    logic                           clk;
    logic                           rst_n;
    logic                           flow_control_enable;
    logic [NP-1:0]                  protocol_enable;
    logic [NP-1:0]                  ul_flit_valid;
    logic [NP-1:0][FLIT_WIDTH-1:0]  ul_flit_data;
    logic [NP-1:0]                  ul_flit_sop;
    logic [NP-1:0]                  ul_flit_eop;
    protocol_t [NP-1:0]             ul_protocol_type;
    logic [NP-1:0][LVC_W-1:0]       ul_vc_id;
    logic [NP-1:0][PRIO_WIDTH-1:0]  ul_priority;
    logic [NP-1:0]                  ul_flit_ready;
    logic                           dl_flit_valid;
    logic [FLIT_WIDTH-1:0]          dl_flit_data;
    logic                           dl_flit_sop;
    logic                           dl_flit_eop;
    protocol_t                      dl_protocol_type;
    logic [VC_ID_WIDTH-1:0]         dl_vc_global_id;
    logic                           dl_flit_ready;
    logic                           credit_return_valid;
    logic [VC_ID_WIDTH-1:0]         credit_return_vc;
    logic [CREDIT_WIDTH-1:0]        credit_return_count;
    logic [TOTAL_VCS-1:0][CREDIT_WIDTH-1:0] credit_available;

    // Credit scoreboard and captured downstream flits
    logic [CREDIT_WIDTH-1:0] exp_credit [TOTAL_VCS];
    flit_entry_t             got_q [$];
    int                      errors = 0;
    int                      cycles = 0;

    flow_ctrl_top #(
        .NUM_PROTOCOLS   (NP),
        .VCS_PER_PROTOCOL(VPP),
        .QUEUE_DEPTH     (QD)
    ) UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .flow_control_enable(flow_control_enable),
        .protocol_enable    (protocol_enable),
        .ul_flit_valid      (ul_flit_valid),
        .ul_flit_data       (ul_flit_data),
        .ul_flit_sop        (ul_flit_sop),
        .ul_flit_eop        (ul_flit_eop),
        .ul_protocol_type   (ul_protocol_type),
        .ul_vc_id           (ul_vc_id),
        .ul_priority        (ul_priority),
        .ul_flit_ready      (ul_flit_ready),
        .dl_flit_valid      (dl_flit_valid),
        .dl_flit_data       (dl_flit_data),
        .dl_flit_sop        (dl_flit_sop),
        .dl_flit_eop        (dl_flit_eop),
        .dl_protocol_type   (dl_protocol_type),
        .dl_vc_global_id    (dl_vc_global_id),
        .dl_flit_ready      (dl_flit_ready),
        .credit_return_valid(credit_return_valid),
        .credit_return_vc   (credit_return_vc),
        .credit_return_count(credit_return_count),
        .credit_available   (credit_available)
    );

`include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Record every downstream transfer
    always @(posedge clk) begin
        if (rst_n && dl_flit_valid && dl_flit_ready) begin
            got_q.push_back(flit_entry_t'{data: dl_flit_data, sop: dl_flit_sop,
                                          eop: dl_flit_eop, protocol: dl_protocol_type,
                                          vc_global: dl_vc_global_id, prio: '0});
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", cycles);
            stop_on_error();
        end
    end

    initial begin
        void'($urandom(32'h9dae));
        rst_n               = 1'b0;
        flow_control_enable = 1'b1;
        protocol_enable     = '1;
        ul_flit_valid       = '0;
        ul_flit_data        = '0;
        ul_flit_sop         = '0;
        ul_flit_eop         = '0;
        ul_vc_id            = '0;
        ul_priority         = '0;
        dl_flit_ready       = 1'b0;
        credit_return_valid = 1'b0;
        credit_return_vc    = '0;
        credit_return_count = '0;
        for (int l = 0; l < NP; l++) begin
            ul_protocol_type[l] = PCIE;
        end
        for (int v = 0; v < TOTAL_VCS; v++) begin
            exp_credit[v] = initial_credits(v, VPP);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_single_flit();
        test_priority_rr();
        test_credit_exhaust();
        test_backpressure_full();

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+testbench
design/flow_ctrl_pkg.sv
design/queue_head_if.sv
design/protocol_queues.sv
design/credit_ledger.sv
design/priority_arbiter.sv
design/flit_out_stage.sv
design/flow_ctrl_top.sv
testbench/tb_flow_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the flow-control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_flow_ctrl \
    -f flist.f \
    -o sim_flow_ctrl

./obj_dir/sim_flow_ctrl
